// ==== rtl/io_pkg.sv ====
package io_pkg;

  // Address windows, word addresses on the 11-bit bus
  localparam logic [10:0] uart_base = 11'h000;
  localparam logic [10:0] uart_last = 11'h007;
  localparam logic [10:0] sw_base   = 11'h010;
  localparam logic [10:0] sw_last   = 11'h013;
  localparam logic [10:0] spi_base  = 11'h020;
  localparam logic [10:0] spi_last  = 11'h027;

  // Picks data (0) or status/control (1) inside a window
  localparam int unsigned reg_sel_bit = 2;

  // Short bit time keeps simulation fast
  localparam int unsigned uart_clks_per_bit = 8;

  // Clock cycles per SCLK half-period
  localparam int unsigned spi_clk_div = 2;

  // UART status word
  localparam int unsigned uart_stat_rx_valid = 0;
  localparam int unsigned uart_stat_tx_busy  = 1;

  // SPI status bits, read at the control address
  localparam int unsigned spi_stat_busy = 0;
  localparam int unsigned spi_stat_wp   = 1;

  // SPI control word fields
  localparam int unsigned spi_ctrl_sel_lsb = 8;
  localparam int unsigned spi_ctrl_itd_lsb = 16;

endpackage

// ==== rtl/uart.sv ====
module uart (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sel,
  input  logic        wr,
  input  logic        reg_sel,
  input  logic [7:0]  wdata,
  input  logic        be0,
  output logic [31:0] rdata,
  input  logic        rx,
  output logic        tx,
  output logic        rx_valid,
  output logic        tx_busy
);
  import io_pkg::*;

  localparam int baud_w = $clog2(uart_clks_per_bit);
  localparam logic [baud_w-1:0] full_last = baud_w'(uart_clks_per_bit - 1);
  localparam logic [baud_w-1:0] half_last = baud_w'(uart_clks_per_bit / 2 - 1);

  logic [9:0]        tx_shift;
  logic [3:0]        tx_bit;
  logic [baud_w-1:0] tx_baud;
  logic              tx_load;

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_busy;
  logic [3:0]        rx_bit;
  logic [baud_w-1:0] rx_baud;
  logic              rx_mid;
  logic [7:0]        rx_shift;
  logic [7:0]        rx_data;
  logic              rd_ack;
  logic [31:0]       status;

  // Writes during a frame are dropped
  assign tx_load = sel & wr & ~reg_sel & be0 & ~tx_busy;

  // Frame is stop, data, start from MSB down to LSB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '1;
      tx_bit   <= '0;
      tx_baud  <= '0;
      tx_busy  <= 1'b0;
    end else if (tx_load) begin
      tx_shift <= {1'b1, wdata, 1'b0};
      tx_bit   <= '0;
      tx_baud  <= '0;
      tx_busy  <= 1'b1;
    end else if (tx_busy) begin
      if (tx_baud == full_last) begin
        tx_baud <= '0;
        if (tx_bit == 4'd9) begin
          tx_busy <= 1'b0;
        end else begin
          tx_bit   <= tx_bit + 4'd1;
          tx_shift <= {1'b1, tx_shift[9:1]};
        end
      end else begin
        tx_baud <= tx_baud + 1'b1;
      end
    end
  end

  assign tx = tx_shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // Half a bit to reach the middle of the start bit, full bits after that
  assign rx_mid = (rx_baud == ((rx_bit == 4'd0) ? half_last : full_last));
  assign rd_ack = sel & ~wr & ~reg_sel;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      rx_bit   <= '0;
      rx_baud  <= '0;
      rx_valid <= 1'b0;
    end else begin
      if (rd_ack) begin
        rx_valid <= 1'b0;
      end
      if (!rx_busy) begin
        if (!rx_sync) begin
          rx_busy <= 1'b1;
          rx_bit  <= '0;
          rx_baud <= '0;
        end
      end else if (rx_mid) begin
        rx_baud <= '0;
        if (rx_bit == 4'd0 && rx_sync) begin
          // Glitch, not a real start bit
          rx_busy <= 1'b0;
        end else if (rx_bit == 4'd9) begin
          rx_busy <= 1'b0;
          if (rx_sync) begin
            rx_valid <= 1'b1;
          end
        end else begin
          rx_bit <= rx_bit + 4'd1;
        end
      end else begin
        rx_baud <= rx_baud + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_busy && rx_mid && rx_bit != 4'd0 && rx_bit != 4'd9) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_busy && rx_mid && rx_bit == 4'd9 && rx_sync) begin
      rx_data <= rx_shift;
    end
  end

  always_comb begin
    status = '0;
    status[uart_stat_rx_valid] = rx_valid;
    status[uart_stat_tx_busy]  = tx_busy;
  end

  assign rdata = reg_sel ? status : {24'h000000, rx_data};

endmodule

// ==== rtl/spi_master.sv ====
module spi_master (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sel,
  input  logic        wr,
  input  logic        reg_sel,
  input  logic [31:0] wdata,
  input  logic [3:0]  be,
  output logic [31:0] rdata,
  input  logic        miso,
  output logic        mosi,
  output logic        sclk,
  output logic [7:0]  selects,
  input  logic        wp_n,
  output logic [1:0]  itd
);
  import io_pkg::*;

  localparam int div_w = (spi_clk_div > 1) ? $clog2(spi_clk_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(spi_clk_div - 1);

  logic             busy;
  logic [div_w-1:0] div_cnt;
  logic [3:0]       half_cnt;
  logic             tick;
  logic             rise;
  logic             fall;
  logic             start;
  logic             ctrl_wr;
  logic [7:0]       shift;
  logic             miso_bit;
  logic [31:0]      ctrl_word;

  assign start   = sel & wr & ~reg_sel & be[0] & ~busy;
  assign ctrl_wr = sel & wr & reg_sel;

  assign tick = busy & (div_cnt == div_last);
  assign rise = tick & ~sclk;
  assign fall = tick & sclk;

  // Sixteen SCLK half-periods per byte, ending on the last falling edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      sclk     <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      sclk     <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else if (busy) begin
      if (tick) begin
        div_cnt  <= '0;
        sclk     <= ~sclk;
        half_cnt <= half_cnt + 4'd1;
        if (half_cnt == 4'd15) begin
          busy <= 1'b0;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Sample on rising SCLK, shift on falling SCLK
  always_ff @(posedge clk) begin
    if (start) begin
      shift <= wdata[7:0];
    end else if (fall) begin
      shift <= {shift[6:0], miso_bit};
    end
    if (rise) begin
      miso_bit <= miso;
    end
  end

  assign mosi = busy & shift[7];

  // Byte-enabled fields, all devices deselected out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= 8'hff;
      itd     <= 2'b00;
    end else if (ctrl_wr) begin
      if (be[1]) begin
        selects <= wdata[spi_ctrl_sel_lsb +: 8];
      end
      if (be[2]) begin
        itd <= wdata[spi_ctrl_itd_lsb +: 2];
      end
    end
  end

  always_comb begin
    ctrl_word = '0;
    ctrl_word[spi_stat_busy] = busy;
    ctrl_word[spi_stat_wp]   = wp_n;
    ctrl_word[spi_ctrl_sel_lsb +: 8] = selects;
    ctrl_word[spi_ctrl_itd_lsb +: 2] = itd;
  end

  assign rdata = reg_sel ? ctrl_word : {24'h000000, shift};

endmodule

// ==== rtl/io_controller.sv ====
module io_controller (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        read,
  input  logic        write,
  input  logic [10:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  be,
  output logic [31:0] data_out,
  output logic        wait_out,
  output logic        tx0,
  input  logic        rx0,
  input  logic        miso,
  output logic        mosi,
  output logic        sclk,
  output logic [7:0]  spi_selects,
  input  logic        sd_wp_n,
  output logic        itd_backlight,
  output logic        itd_dc,
  output logic [1:0]  interrupt,
  input  logic [15:0] sw
);
  import io_pkg::*;

  logic [1:0]  iodelay;
  logic        second_cycle;
  logic        uart_hit;
  logic        sw_hit;
  logic        spi_hit;
  logic        uart_sel;
  logic        spi_sel;
  logic        wr_pulse;
  logic        reg_sel;
  logic [31:0] uart_rdata;
  logic [31:0] spi_rdata;
  logic [15:0] sw_meta;
  logic [15:0] sw_sync;
  logic        rx_valid;
  logic        tx_busy;

  // Shift register reloads to all ones whenever the bus is idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iodelay <= 2'b11;
    end else if (read | write) begin
      iodelay <= {iodelay[0], 1'b0};
    end else begin
      iodelay <= 2'b11;
    end
  end

  assign wait_out = iodelay[0];

  // High for exactly one cycle per access, even if a strobe is held longer
  assign second_cycle = iodelay[1] & ~iodelay[0];

  assign uart_hit = (address >= uart_base) && (address <= uart_last);
  assign sw_hit   = (address >= sw_base) && (address <= sw_last);
  assign spi_hit  = (address >= spi_base) && (address <= spi_last);

  assign uart_sel = uart_hit & (read | write) & second_cycle;
  assign spi_sel  = spi_hit & (read | write) & second_cycle;
  assign wr_pulse = write & second_cycle;
  assign reg_sel  = address[reg_sel_bit];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  always_comb begin
    data_out = '0;
    if (uart_hit) begin
      data_out = uart_rdata;
    end else if (sw_hit) begin
      data_out = {16'h0000, sw_sync};
    end else if (spi_hit) begin
      data_out = spi_rdata;
    end
  end

  assign interrupt = {~tx_busy, rx_valid};

  uart u_uart (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel      (uart_sel),
    .wr       (wr_pulse),
    .reg_sel  (reg_sel),
    .wdata    (data_in[7:0]),
    .be0      (be[0]),
    .rdata    (uart_rdata),
    .rx       (rx0),
    .tx       (tx0),
    .rx_valid (rx_valid),
    .tx_busy  (tx_busy)
  );

  spi_master u_spi (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (spi_sel),
    .wr      (wr_pulse),
    .reg_sel (reg_sel),
    .wdata   (data_in),
    .be      (be),
    .rdata   (spi_rdata),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk),
    .selects (spi_selects),
    .wp_n    (sd_wp_n),
    .itd     ({itd_backlight, itd_dc})
  );

endmodule

// ==== testbench/io_checker.sv ====
module io_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        read,
  input  logic        write,
  input  logic [10:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  be,
  input  logic [31:0] data_out,
  input  logic        wait_out,
  input  logic        tx0,
  input  logic        mosi,
  input  logic        sclk,
  input  logic [7:0]  spi_selects,
  input  logic        sd_wp_n,
  input  logic        itd_backlight,
  input  logic        itd_dc,
  input  logic [1:0]  interrupt,
  input  logic [15:0] sw,
  input  int          test_id,
  output int          checks,
  output int          errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import io_pkg::*;

  int         phase = 0;
  int         cur_test = 0;
  int         test_checks = 0;
  int         test_errors = 0;
  logic [7:0] rx_expect;
  logic [7:0] spi_expect;
  logic       rx_known = 1'b0;
  logic       spi_known = 1'b0;
  logic       frame_pending = 1'b0;
  logic [7:0] sel_model = 8'hff;
  logic [1:0] itd_model = 2'b00;
  int         tx_left = 0;
  int         spi_left = 0;
  logic       tx_start = 1'b0;
  logic       spi_start = 1'b0;

  function automatic logic in_window(input logic [10:0] a, input logic [10:0] lo,
                                     input logic [10:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset and wait state";
      2: return "decode";
      3: return "uart loopback";
      4: return "spi loopback and control";
      default: return "write protect status";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Called in the second cycle of an access, while data_out is valid
  task automatic finish_access();
    logic [31:0] exp;
    exp = '0;
    if (write) begin
      if (in_window(address, uart_base, uart_last) && !address[reg_sel_bit]) begin
        if (be[0] && tx_left == 0) begin
          rx_expect = data_in[7:0];
          rx_known = 1'b1;
          frame_pending = 1'b1;
          tx_start = 1'b1;
        end
      end else if (in_window(address, spi_base, spi_last)) begin
        if (!address[reg_sel_bit]) begin
          if (be[0] && spi_left == 0) begin
            spi_expect = data_in[7:0];
            spi_known = 1'b1;
            spi_start = 1'b1;
          end
        end else begin
          if (be[1]) begin
            sel_model = data_in[spi_ctrl_sel_lsb +: 8];
          end
          if (be[2]) begin
            itd_model = data_in[spi_ctrl_itd_lsb +: 2];
          end
        end
      end
    end else if (in_window(address, uart_base, uart_last)) begin
      if (address[reg_sel_bit]) begin
        compare("uart status", data_out & ~32'h3, 32'h0);
        compare("tx_busy", data_out[uart_stat_tx_busy], tx_left != 0);
        // Receiver may finish just before the transmitter
        if (!frame_pending || tx_left == 0) begin
          compare("rx_valid", data_out[uart_stat_rx_valid], frame_pending);
        end
      end else begin
        if (rx_known) begin
          compare("data_out", data_out, {24'h0, rx_expect});
        end
        frame_pending = 1'b0;
      end
    end else if (in_window(address, sw_base, sw_last)) begin
      compare("data_out", data_out, {16'h0, sw});
    end else if (in_window(address, spi_base, spi_last)) begin
      if (address[reg_sel_bit]) begin
        exp[spi_stat_busy] = (spi_left != 0);
        exp[spi_stat_wp] = sd_wp_n;
        exp[spi_ctrl_sel_lsb +: 8] = sel_model;
        exp[spi_ctrl_itd_lsb +: 2] = itd_model;
        compare("spi control word", data_out, exp);
      end else if (spi_known) begin
        compare("data_out", data_out, {24'h0, spi_expect});
      end
    end else begin
      compare("data_out", data_out, 32'h0);
    end
  endtask

  // Busy windows open on the edge that ends the write
  always @(posedge clk) begin
    if (tx_start) begin
      tx_left = 10 * uart_clks_per_bit;
      tx_start = 1'b0;
    end else if (tx_left > 0) begin
      tx_left--;
    end
    if (spi_start) begin
      spi_left = 16 * spi_clk_div;
      spi_start = 1'b0;
    end else if (spi_left > 0) begin
      spi_left--;
    end
  end

  always @(posedge rst_n) begin
    compare("tx0", tx0, 1);
    compare("mosi", mosi, 0);
    compare("sclk", sclk, 0);
    compare("spi_selects", spi_selects, 8'hff);
    compare("itd", {itd_backlight, itd_dc}, 2'b00);
    // Idle transmitter raises interrupt[1]
    compare("interrupt", interrupt, 2'b10);
    compare("wait_out", wait_out, 1);
  end

  always @(negedge clk) begin
    if (rst_n) begin
      compare("spi_selects", spi_selects, sel_model);
      compare("itd", {itd_backlight, itd_dc}, itd_model);
      compare("interrupt[1]", interrupt[1], tx_left == 0);
      if (!frame_pending || tx_left == 0) begin
        compare("interrupt[0]", interrupt[0], frame_pending);
      end
      if (tx_left == 0) begin
        compare("tx0", tx0, 1);
      end
      if (spi_left == 0) begin
        compare("sclk", sclk, 0);
      end
      if (read || write) begin
        if (phase == 0) begin
          compare("wait_out", wait_out, 1);
          phase = 1;
        end else if (phase == 1) begin
          compare("wait_out", wait_out, 0);
          finish_access();
          phase = 2;
        end
      end else begin
        phase = 0;
      end
    end
  end

  always @(test_id) begin
    if (cur_test > 0) begin
      $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
               test_checks, test_errors);
    end
    cur_test = test_id;
    test_checks = 0;
    test_errors = 0;
  end

endmodule

// ==== testbench/tb_io_controller.sv ====
module tb_io_controller;
  timeunit 1ns;
  timeprecision 100ps;
  import io_pkg::*;

  // About twice the summed length of all tests
  localparam int timeout_cycles = 4000;

  logic        clk;
  logic        rst_n;
  logic        read;
  logic        write;
  logic [10:0] address;
  logic [31:0] data_in;
  logic [3:0]  be;
  logic [31:0] data_out;
  logic        wait_out;
  logic        tx0;
  logic        mosi;
  logic        sclk;
  logic [7:0]  spi_selects;
  logic        sd_wp_n;
  logic        itd_backlight;
  logic        itd_dc;
  logic [1:0]  interrupt;
  logic [15:0] sw;
  int          test_id = 0;
  int          checks;
  int          errors;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'd88;

  // UART and SPI both looped back
  io_controller u_io_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .read          (read),
    .write         (write),
    .address       (address),
    .data_in       (data_in),
    .be            (be),
    .data_out      (data_out),
    .wait_out      (wait_out),
    .tx0           (tx0),
    .rx0           (tx0),
    .miso          (mosi),
    .mosi          (mosi),
    .sclk          (sclk),
    .spi_selects   (spi_selects),
    .sd_wp_n       (sd_wp_n),
    .itd_backlight (itd_backlight),
    .itd_dc        (itd_dc),
    .interrupt     (interrupt),
    .sw            (sw)
  );

  io_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Halves swapped so the low bits come from the better upper state bits
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic is_mapped(input logic [10:0] a);
    return (a >= uart_base && a <= uart_last) || (a >= sw_base && a <= sw_last) ||
           (a >= spi_base && a <= spi_last);
  endfunction

  task automatic bus_access(input logic is_write, input logic [10:0] addr,
                            input logic [31:0] wdata, input logic [3:0] byte_en,
                            output logic [31:0] rdata);
    @(posedge clk);
    #2;
    read = ~is_write;
    write = is_write;
    address = addr;
    data_in = wdata;
    be = byte_en;
    @(negedge clk);
    while (wait_out) begin
      @(negedge clk);
    end
    rdata = data_out;
    @(posedge clk);
    #2;
    read = 1'b0;
    write = 1'b0;
  endtask

  task automatic bus_write(input logic [10:0] addr, input logic [31:0] wdata,
                           input logic [3:0] byte_en);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, byte_en, unused);
  endtask

  task automatic bus_read(input logic [10:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, 4'h0, rdata);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [10:0] a;
    rst_n = 1'b0;
    read = 1'b0;
    write = 1'b0;
    address = '0;
    data_in = '0;
    be = '0;
    sd_wp_n = 1'b1;
    sw = 16'h0000;
    @(posedge clk);
    #2;
    test_id = 1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = next_random();
      bus_read({5'b0, r[5:0]}, d);
    end

    test_id = 2;
    for (int i = 0; i < 12; i++) begin
      do begin
        r = next_random();
        a = r[10:0];
      end while (is_mapped(a));
      bus_read(a, d);
    end
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      @(posedge clk);
      #2;
      sw = r[31:16];
      repeat (2) @(posedge clk);
      bus_read(sw_base + {9'b0, r[1:0]}, d);
    end

    test_id = 3;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      bus_write(uart_base + {9'b0, r[1:0]}, r, {r[31:29], 1'b1});
      do begin
        bus_read(uart_base + 11'd4, d);
      end while (!d[uart_stat_rx_valid] || d[uart_stat_tx_busy]);
      bus_read(uart_base + {9'b0, r[3:2]}, d);
    end
    // No frame may follow a write with be[0] clear
    r = next_random();
    bus_write(uart_base + {9'b0, r[1:0]}, r, {r[31:29], 1'b0});
    repeat (12 * uart_clks_per_bit) @(posedge clk);
    bus_read(uart_base + 11'd4, d);

    test_id = 4;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      bus_write(spi_base + 11'd4 + {9'b0, r[1:0]}, r, r[31:28]);
      bus_read(spi_base + 11'd4 + {9'b0, r[3:2]}, d);
    end
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      bus_write(spi_base + {9'b0, r[1:0]}, r, {r[31:29], 1'b1});
      do begin
        bus_read(spi_base + 11'd4, d);
      end while (d[spi_stat_busy]);
      bus_read(spi_base + {9'b0, r[3:2]}, d);
    end

    test_id = 5;
    for (int i = 0; i < 4; i++) begin
      r = next_random();
      @(posedge clk);
      #2;
      sd_wp_n = ~sd_wp_n;
      bus_read(spi_base + 11'd4 + {9'b0, r[1:0]}, d);
    end

    test_id = 6;
    @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
rtl/io_pkg.sv
rtl/uart.sv
rtl/spi_master.sv
rtl/io_controller.sv
testbench/io_checker.sv
testbench/tb_io_controller.sv

// ==== Bender.yml ====
package:
  name: io_controller

sources:
  - rtl/io_pkg.sv
  - rtl/uart.sv
  - rtl/spi_master.sv
  - rtl/io_controller.sv
  - target: test
    files:
      - testbench/io_checker.sv
      - testbench/tb_io_controller.sv
